// ==== verif/portalTestdata.txt ====
// op addr len id data expect (hex); op 1 read, 2 write, 3 write beat, 4 push indication,
// 5 read beat expect, 6 irq expect, 7 random ready on/off, 0 end; op 3 expect = channel
1 000 7 03 00000000 00000000
5 000 0 00 00000000 00000000
5 000 0 00 00000000 00000000
5 000 0 00 00000000 00000001
5 000 0 00 00000000 00000000
5 000 0 00 00000000 00000005
5 000 0 00 00000000 00000002
5 000 0 00 00000000 005A05A0
5 000 0 00 00000000 005A05A0
2 004 0 11 00000000 00000000
3 000 0 00 00000001 00000000
6 000 0 00 00000000 00000000
4 000 0 00 CAFE0001 00000000
6 000 0 00 00000000 00000001
1 004 0 04 00000000 00000000
5 000 0 00 00000000 00000001
2 004 0 12 00000000 00000000
3 000 0 00 00000000 00000000
6 000 0 00 00000000 00000000
2 AA0 2 21 00000000 00000000
3 000 0 00 11111111 00000015
3 000 0 00 22222222 00000015
3 000 0 00 33333333 00000015
4 000 0 00 CAFE0002 00000000
1 860 2 05 00000000 00000000
5 000 0 00 00000000 CAFE0001
5 000 0 00 00000000 CAFE0002
5 000 0 00 00000000 00000000
7 000 0 00 00000001 00000000
1 008 3 07 00000000 00000000
5 000 0 00 00000000 00000001
5 000 0 00 00000000 00000002
5 000 0 00 00000000 00000005
5 000 0 00 00000000 00000002
2 FE0 3 2A 00000000 00000000
3 000 0 00 A0000000 0000003F
3 000 0 00 A0000001 0000003F
3 000 0 00 A0000002 0000003F
3 000 0 00 A0000003 0000003F
4 000 0 00 AAAA5555 00000000
1 820 1 08 00000000 00000000
5 000 0 00 00000000 AAAA5555
5 000 0 00 00000000 00000000
1 00C 0 09 00000000 00000000
5 000 0 00 00000000 00000003
0 000 0 00 00000000 00000000

// ==== sources.f ====
hdl/portalPkg.sv
hdl/wordFifo.sv
hdl/portalRead.sv
hdl/portalWrite.sv
hdl/portalRegs.sv
hdl/portalTop.sv
verif/portalTb.sv

// ==== verif/portalTb.sv ====
module portalTb;

  logic CLK = 1'b0;
  logic nRST;
  logic arValid, arReady, rValid, rReady, rLast;
  logic [11:0] arAddr, awAddr;
  logic [3:0] arLen, awLen;
  logic [5:0] arId, rId, awId, bId, reqChannel;
  logic [31:0] rData, wData, reqData, indData;
  logic awValid, awReady, wValid, wReady, wLast, bValid, bReady;
  logic [1:0] bResp;
  logic reqValid, reqReady, indValid, indReady, irq;

  logic [31:0] vec [0:383];   // six words per vector line
  logic [31:0] rDataQ[$];
  logic [6:0] rTagQ[$];       // {id, last}
  logic [7:0] bQ[$];          // {id, resp}
  logic [37:0] reqQ[$];       // {channel, data}
  logic [31:0] indQ[$];
  bit jitter = 1'b0;
  int errors = 0;
  int checks = 0;
  int cycles = 0;
  int cycleLimit = 0;

  portalTop i_portalTop (.*);

  initial begin
    forever #20 CLK = ~CLK;
  end

  task automatic checkValue(input string name, input logic [63:0] expected,
                            input logic [63:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Error %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  task automatic readBurst(input int at);
    int beats;
    int i;
    beats = vec[6 * at + 2] + 1;
    arAddr <= vec[6 * at + 1][11:0];
    arLen <= vec[6 * at + 2][3:0];
    arId <= vec[6 * at + 3][5:0];
    arValid <= 1'b1;
    do @(posedge CLK); while (!arReady);
    arValid <= 1'b0;
    while (rDataQ.size() < beats) @(posedge CLK);
    for (i = 0; i < beats; i++) begin
      checkValue($sformatf("line %0d read data", at + 1 + i), vec[6 * (at + 1 + i) + 5],
                 rDataQ.pop_front());
      checkValue($sformatf("line %0d read id and last", at + 1 + i),
                 {vec[6 * at + 3][5:0], i == beats - 1}, rTagQ.pop_front());
    end
  endtask

  task automatic writeBurst(input int at);
    int beats;
    int i;
    logic user;
    beats = vec[6 * at + 2] + 1;
    user = vec[6 * at + 1][11];   // page bit
    awAddr <= vec[6 * at + 1][11:0];
    awLen <= vec[6 * at + 2][3:0];
    awId <= vec[6 * at + 3][5:0];
    awValid <= 1'b1;
    do @(posedge CLK); while (!awReady);
    awValid <= 1'b0;
    for (i = 0; i < beats; i++) begin
      wData <= vec[6 * (at + 1 + i) + 4];
      wLast <= i == beats - 1;
      wValid <= 1'b1;
      do @(posedge CLK); while (!wReady);
    end
    wValid <= 1'b0;
    while (bQ.size() == 0 || (user && reqQ.size() < beats)) @(posedge CLK);
    // responses are always OKAY, code 0
    checkValue($sformatf("line %0d write response", at),
               {vec[6 * at + 3][5:0], 2'b00}, bQ.pop_front());
    for (i = 0; i < beats && user; i++) begin
      checkValue($sformatf("line %0d request", at + 1 + i),
                 {vec[6 * (at + 1 + i) + 5][5:0], vec[6 * (at + 1 + i) + 4]},
                 reqQ.pop_front());
    end
  endtask

  // ready toggling for the three sinks
  initial begin
    void'($urandom(32'hd7bd_39f5));
    rReady = 1'b1;
    bReady = 1'b1;
    reqReady = 1'b1;
    forever begin
      @(posedge CLK);
      rReady <= !jitter || ($urandom % 4 != 0);
      bReady <= !jitter || ($urandom % 3 != 0);
      reqReady <= !jitter || ($urandom % 4 != 0);
    end
  end

  // collects handshakes seen at the edge and feeds the indication stream
  always @(posedge CLK) begin
    if (rValid && rReady) begin
      rDataQ.push_back(rData);
      rTagQ.push_back({rId, rLast});
    end
    if (bValid && bReady) bQ.push_back({bId, bResp});
    if (reqValid && reqReady) reqQ.push_back({reqChannel, reqData});
    if (indValid && indReady) void'(indQ.pop_front());
    indValid <= indQ.size() != 0;
    indData <= (indQ.size() != 0) ? indQ[0] : '0;
  end

  initial begin
    wait (cycleLimit != 0);
    while (cycles < cycleLimit) begin
      @(posedge CLK);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
    $display("%0d checks, %0d errors", checks, errors);
    $display("Checks failed");
    $finish;
  end

  initial begin
    int pc;
    int lines;
    {arValid, arAddr, arLen, arId, awValid, awAddr, awLen, awId} = '0;
    {wValid, wData, wLast, indValid, indData} = '0;
    nRST = 1'b0;
    $readmemh("verif/portalTestdata.txt", vec);
    lines = 0;
    while (lines < 64 && vec[6 * lines] !== 32'h0) lines++;
    if (lines == 0) begin
      $display("No test vectors found in verif/portalTestdata.txt");
      errors++;
    end
    cycleLimit = 200 * (lines + 1);
    repeat (8) @(posedge CLK);
    nRST <= 1'b1;
    @(posedge CLK);
    checkValue("reset rValid", 0, rValid);
    checkValue("reset bValid", 0, bValid);
    checkValue("reset reqValid", 0, reqValid);
    checkValue("reset irq", 0, irq);
    pc = 0;
    while (pc < lines) begin
      case (vec[6 * pc])
        32'd1: readBurst(pc);
        32'd2: writeBurst(pc);
        32'd4: begin
          indQ.push_back(vec[6 * pc + 4]);
          while (!indValid) @(posedge CLK);
        end
        32'd6: checkValue($sformatf("line %0d irq", pc), vec[6 * pc + 5], irq);
        32'd7: jitter <= vec[6 * pc + 4][0];
        default: begin
          $display("Unknown operation %0h on vector line %0d", vec[6 * pc], pc);
          errors++;
        end
      endcase
      if (vec[6 * pc] == 32'd1 || vec[6 * pc] == 32'd2) pc += vec[6 * pc + 2] + 2;
      else pc++;
    end
    checkValue("extra read beats", 0, rDataQ.size());
    checkValue("extra write responses", 0, bQ.size());
    checkValue("extra requests", 0, reqQ.size());
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// ==== hdl/portalTop.sv ====
module portalTop (
  input  logic CLK,
  input  logic nRST,
  input  logic arValid,
  output logic arReady,
  input  logic [portalPkg::ADDR_WIDTH-1:0] arAddr,
  input  logic [portalPkg::LEN_WIDTH-1:0] arLen,
  input  logic [portalPkg::ID_WIDTH-1:0] arId,
  output logic rValid,
  input  logic rReady,
  output logic [portalPkg::DATA_WIDTH-1:0] rData,
  output logic [portalPkg::ID_WIDTH-1:0] rId,
  output logic rLast,
  input  logic awValid,
  output logic awReady,
  input  logic [portalPkg::ADDR_WIDTH-1:0] awAddr,
  input  logic [portalPkg::LEN_WIDTH-1:0] awLen,
  input  logic [portalPkg::ID_WIDTH-1:0] awId,
  input  logic wValid,
  output logic wReady,
  input  logic [portalPkg::DATA_WIDTH-1:0] wData,
  input  logic wLast,
  output logic bValid,
  input  logic bReady,
  output logic [portalPkg::ID_WIDTH-1:0] bId,
  output logic [portalPkg::RESP_WIDTH-1:0] bResp,
  output logic reqValid,
  input  logic reqReady,
  output logic [portalPkg::DATA_WIDTH-1:0] reqData,
  output logic [portalPkg::CHAN_WIDTH-1:0] reqChannel,
  input  logic indValid,
  output logic indReady,
  input  logic [portalPkg::DATA_WIDTH-1:0] indData,
  output logic irq
);

  logic rdBeatValid;
  logic rdBeatReady;
  logic [portalPkg::ADDR_WIDTH-1:0] rdBeatAddr;
  logic [portalPkg::DATA_WIDTH-1:0] rdBeatData;
  logic rdSpace;
  logic wrBeatValid;
  logic wrBeatReady;
  logic [portalPkg::ADDR_WIDTH-1:0] wrBeatAddr;
  logic [portalPkg::DATA_WIDTH-1:0] wrBeatData;

  portalRead i_portalRead (
    .CLK(CLK), .nRST(nRST),
    .arValid(arValid), .arReady(arReady), .arAddr(arAddr), .arLen(arLen), .arId(arId),
    .rValid(rValid), .rReady(rReady), .rData(rData), .rId(rId), .rLast(rLast),
    .rdBeatValid(rdBeatValid), .rdBeatReady(rdBeatReady), .rdBeatAddr(rdBeatAddr),
    .rdBeatData(rdBeatData), .rdSpace(rdSpace)
  );

  portalWrite i_portalWrite (
    .CLK(CLK), .nRST(nRST),
    .awValid(awValid), .awReady(awReady), .awAddr(awAddr), .awLen(awLen), .awId(awId),
    .wValid(wValid), .wReady(wReady), .wData(wData), .wLast(wLast),
    .bValid(bValid), .bReady(bReady), .bId(bId), .bResp(bResp),
    .wrBeatValid(wrBeatValid), .wrBeatReady(wrBeatReady), .wrBeatAddr(wrBeatAddr),
    .wrBeatData(wrBeatData)
  );

  portalRegs i_portalRegs (
    .CLK(CLK), .nRST(nRST),
    .rdBeatValid(rdBeatValid), .rdBeatReady(rdBeatReady), .rdBeatAddr(rdBeatAddr),
    .rdBeatData(rdBeatData), .rdSpace(rdSpace),
    .wrBeatValid(wrBeatValid), .wrBeatReady(wrBeatReady), .wrBeatAddr(wrBeatAddr),
    .wrBeatData(wrBeatData),
    .reqValid(reqValid), .reqReady(reqReady), .reqData(reqData), .reqChannel(reqChannel),
    .indValid(indValid), .indReady(indReady), .indData(indData),
    .irq(irq)
  );

endmodule

// ==== hdl/portalRegs.sv ====
module portalRegs (
  input  logic CLK,
  input  logic nRST,
  input  logic rdBeatValid,
  output logic rdBeatReady,
  input  logic [portalPkg::ADDR_WIDTH-1:0] rdBeatAddr,
  output logic [portalPkg::DATA_WIDTH-1:0] rdBeatData,
  input  logic rdSpace,
  input  logic wrBeatValid,
  output logic wrBeatReady,
  input  logic [portalPkg::ADDR_WIDTH-1:0] wrBeatAddr,
  input  logic [portalPkg::DATA_WIDTH-1:0] wrBeatData,
  output logic reqValid,
  input  logic reqReady,
  output logic [portalPkg::DATA_WIDTH-1:0] reqData,
  output logic [portalPkg::CHAN_WIDTH-1:0] reqChannel,
  input  logic indValid,
  output logic indReady,
  input  logic [portalPkg::DATA_WIDTH-1:0] indData,
  output logic irq
);

  portalPkg::portalAddr_t rdAddr;
  portalPkg::portalAddr_t wrAddr;
  logic rdFire;
  logic wrFire;
  logic rdUser;
  logic wrUser;
  logic intEnable;
  logic [portalPkg::DATA_WIDTH-1:0] indCount;
  logic [portalPkg::DATA_WIDTH-1:0] ctrlValue;

  assign rdAddr = rdBeatAddr;
  assign wrAddr = wrBeatAddr;
  assign rdUser = rdAddr.user.page == portalPkg::PAGE_USER;
  assign wrUser = wrAddr.user.page == portalPkg::PAGE_USER;

  assign rdBeatReady = rdSpace;
  assign rdFire = rdBeatValid && rdBeatReady;
  assign indReady = rdFire && rdUser;   // pop in the cycle of the beat

  always_comb begin
    case (rdAddr.ctrl.regIdx)
      portalPkg::REG_INT_STATUS: ctrlValue = {{(portalPkg::DATA_WIDTH-1){1'b0}}, indValid};
      portalPkg::REG_INT_ENABLE: ctrlValue = {{(portalPkg::DATA_WIDTH-1){1'b0}}, intEnable};
      portalPkg::REG_NUM_TILES: ctrlValue = portalPkg::NUM_TILES;
      portalPkg::REG_IND_COUNT: ctrlValue = indCount;
      portalPkg::REG_PORTAL_ID: ctrlValue = portalPkg::PORTAL_ID;
      portalPkg::REG_NUM_PORTALS: ctrlValue = portalPkg::NUM_PORTALS;
      default: ctrlValue = portalPkg::REG_DEFAULT;
    endcase
  end

  // empty indication queue reads as zero
  assign rdBeatData = !rdUser ? ctrlValue : (indValid ? indData : '0);

  // user beats need the request register free, or leaving this cycle
  assign wrBeatReady = !wrUser || !reqValid || reqReady;
  assign wrFire = wrBeatValid && wrBeatReady;

  always_ff @(posedge CLK) begin
    if (!nRST) begin
      intEnable <= 1'b0;
      indCount <= '0;
      reqValid <= 1'b0;
    end else begin
      if (wrFire && !wrUser && wrAddr.ctrl.regIdx == portalPkg::REG_INT_ENABLE) begin
        intEnable <= wrBeatData[0];
      end
      if (indValid && indReady) indCount <= indCount + 1'b1;
      if (wrFire && wrUser) reqValid <= 1'b1;
      else if (reqReady) reqValid <= 1'b0;
    end
  end

  always_ff @(posedge CLK) begin
    if (wrFire && wrUser) begin
      reqData <= wrBeatData;
      reqChannel <= wrAddr.user.channel;
    end
  end

  assign irq = indValid && intEnable;

  assert property (@(posedge CLK) disable iff (!nRST)
    reqValid && !reqReady |=> $stable(reqData) && $stable(reqChannel));

endmodule

// ==== hdl/portalWrite.sv ====
module portalWrite (
  input  logic CLK,
  input  logic nRST,
  input  logic awValid,
  output logic awReady,
  input  logic [portalPkg::ADDR_WIDTH-1:0] awAddr,
  input  logic [portalPkg::LEN_WIDTH-1:0] awLen,
  input  logic [portalPkg::ID_WIDTH-1:0] awId,
  input  logic wValid,
  output logic wReady,
  input  logic [portalPkg::DATA_WIDTH-1:0] wData,
  input  logic wLast,
  output logic bValid,
  input  logic bReady,
  output logic [portalPkg::ID_WIDTH-1:0] bId,
  output logic [portalPkg::RESP_WIDTH-1:0] bResp,
  output logic wrBeatValid,
  input  logic wrBeatReady,
  output logic [portalPkg::ADDR_WIDTH-1:0] wrBeatAddr,
  output logic [portalPkg::DATA_WIDTH-1:0] wrBeatData
);

  logic cmdValid;
  logic cmdReady;
  logic [portalPkg::CMD_WIDTH-1:0] cmdData;
  logic [portalPkg::ADDR_WIDTH-1:0] headAddr;
  logic [portalPkg::LEN_WIDTH-1:0] headLen;
  logic [portalPkg::ID_WIDTH-1:0] headId;

  logic datValid;
  logic datReady;
  logic [portalPkg::WDQ_WIDTH-1:0] datEntry;
  logic datLast;

  logic respSpace;
  logic [portalPkg::LEN_WIDTH-1:0] beatCnt;
  logic [portalPkg::ADDR_WIDTH-1:0] nextAddr;
  logic lastBeat;
  logic beatFire;

  wordFifo #(.WIDTH(portalPkg::CMD_WIDTH)) i_cmdFifo (
    .CLK(CLK),
    .nRST(nRST),
    .inValid(awValid),
    .inReady(awReady),
    .inData({awId, awLen, awAddr}),
    .outValid(cmdValid),
    .outReady(cmdReady),
    .outData(cmdData)
  );

  wordFifo #(.WIDTH(portalPkg::WDQ_WIDTH)) i_dataFifo (
    .CLK(CLK),
    .nRST(nRST),
    .inValid(wValid),
    .inReady(wReady),
    .inData({wData, wLast}),
    .outValid(datValid),
    .outReady(datReady),
    .outData(datEntry)
  );

  assign {headId, headLen, headAddr} = cmdData;
  assign {wrBeatData, datLast} = datEntry;

  assign wrBeatAddr = (beatCnt == '0) ? headAddr : nextAddr;
  assign lastBeat = beatCnt == headLen;
  // final beat waits for room in the response queue
  assign wrBeatValid = cmdValid && datValid && (!lastBeat || respSpace);
  assign beatFire = wrBeatValid && wrBeatReady;
  assign datReady = beatFire;
  assign cmdReady = beatFire && lastBeat;

  always_ff @(posedge CLK) begin
    if (!nRST) begin
      beatCnt <= '0;
    end else if (beatFire) begin
      beatCnt <= lastBeat ? '0 : beatCnt + 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (beatFire) nextAddr <= wrBeatAddr + portalPkg::BEAT_STEP;
  end

  wordFifo #(.WIDTH(portalPkg::ID_WIDTH)) i_respFifo (
    .CLK(CLK),
    .nRST(nRST),
    .inValid(beatFire && lastBeat),
    .inReady(respSpace),
    .inData(headId),
    .outValid(bValid),
    .outReady(bReady),
    .outData(bId)
  );

  assign bResp = portalPkg::RESP_OKAY;   // no error responses

  // wLast from the master has to agree with awLen of the matching burst
  assert property (@(posedge CLK) disable iff (!nRST)
    beatFire |-> (datLast == lastBeat));

endmodule

// ==== hdl/portalRead.sv ====
module portalRead (
  input  logic CLK,
  input  logic nRST,
  input  logic arValid,
  output logic arReady,
  input  logic [portalPkg::ADDR_WIDTH-1:0] arAddr,
  input  logic [portalPkg::LEN_WIDTH-1:0] arLen,
  input  logic [portalPkg::ID_WIDTH-1:0] arId,
  output logic rValid,
  input  logic rReady,
  output logic [portalPkg::DATA_WIDTH-1:0] rData,
  output logic [portalPkg::ID_WIDTH-1:0] rId,
  output logic rLast,
  output logic rdBeatValid,
  input  logic rdBeatReady,
  output logic [portalPkg::ADDR_WIDTH-1:0] rdBeatAddr,
  input  logic [portalPkg::DATA_WIDTH-1:0] rdBeatData,
  output logic rdSpace
);

  logic cmdValid;
  logic cmdReady;
  logic [portalPkg::CMD_WIDTH-1:0] cmdData;
  logic [portalPkg::ADDR_WIDTH-1:0] headAddr;
  logic [portalPkg::LEN_WIDTH-1:0] headLen;
  logic [portalPkg::ID_WIDTH-1:0] headId;

  logic [portalPkg::LEN_WIDTH-1:0] beatCnt;   // beats already sent for head burst
  logic [portalPkg::ADDR_WIDTH-1:0] nextAddr;
  logic lastBeat;
  logic beatFire;

  wordFifo #(.WIDTH(portalPkg::CMD_WIDTH)) i_cmdFifo (
    .CLK(CLK),
    .nRST(nRST),
    .inValid(arValid),
    .inReady(arReady),
    .inData({arId, arLen, arAddr}),
    .outValid(cmdValid),
    .outReady(cmdReady),
    .outData(cmdData)
  );

  assign {headId, headLen, headAddr} = cmdData;

  assign rdBeatAddr = (beatCnt == '0) ? headAddr : nextAddr;
  assign lastBeat = beatCnt == headLen;
  assign rdBeatValid = cmdValid;
  assign beatFire = rdBeatValid && rdBeatReady;
  assign cmdReady = beatFire && lastBeat;   // drop burst after its final beat

  always_ff @(posedge CLK) begin
    if (!nRST) begin
      beatCnt <= '0;
    end else if (beatFire) begin
      beatCnt <= lastBeat ? '0 : beatCnt + 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (beatFire) nextAddr <= rdBeatAddr + portalPkg::BEAT_STEP;
  end

  wordFifo #(.WIDTH(portalPkg::RDQ_WIDTH)) i_respFifo (
    .CLK(CLK),
    .nRST(nRST),
    .inValid(beatFire),
    .inReady(rdSpace),
    .inData({rdBeatData, headId, lastBeat}),
    .outValid(rValid),
    .outReady(rReady),
    .outData({rData, rId, rLast})
  );

  // last flag only changes together with a newly queued response
  assert property (@(posedge CLK) disable iff (!nRST)
    $rose(rLast) |-> rValid);

endmodule

// ==== hdl/wordFifo.sv ====
module wordFifo #(
  parameter int WIDTH = 32
) (
  input  logic CLK,
  input  logic nRST,
  input  logic inValid,
  output logic inReady,
  input  logic [WIDTH-1:0] inData,
  output logic outValid,
  input  logic outReady,
  output logic [WIDTH-1:0] outData
);

  logic [WIDTH-1:0] head;   // entry 0 always feeds the output
  logic [WIDTH-1:0] tail;
  logic [1:0] count;
  logic push;
  logic pop;

  assign inReady = count != 2'd2;
  assign outValid = count != 2'd0;
  assign outData = head;
  assign push = inValid && inReady;
  assign pop = outValid && outReady;

  always_ff @(posedge CLK) begin
    if (!nRST) begin
      count <= 2'd0;
    end else begin
      count <= count + {1'b0, push} - {1'b0, pop};
    end
  end

  always_ff @(posedge CLK) begin
    case (count)
      2'd0: if (push) head <= inData;
      2'd1: begin
        if (push && pop) head <= inData;   // pass-through at full rate
        else if (push) tail <= inData;
      end
      default: if (pop) head <= tail;
    endcase
  end

  // producer must hold its word until taken
  assert property (@(posedge CLK) disable iff (!nRST)
    inValid && !inReady |=> $stable(inData));

endmodule

// ==== hdl/portalPkg.sv ====
package portalPkg;

  localparam int ADDR_WIDTH = 12;
  localparam int DATA_WIDTH = 32;
  localparam int ID_WIDTH = 6;
  localparam int LEN_WIDTH = 4;   // beats = len + 1
  localparam int CHAN_WIDTH = 6;
  localparam int REG_IDX_WIDTH = 3;
  localparam int OFFSET_WIDTH = 3;
  localparam int RESP_WIDTH = 2;

  // queued burst command: {id, len, addr}
  localparam int CMD_WIDTH = ID_WIDTH + LEN_WIDTH + ADDR_WIDTH;
  // read response entry: {data, id, last}
  localparam int RDQ_WIDTH = DATA_WIDTH + ID_WIDTH + 1;
  // write data entry: {data, last}
  localparam int WDQ_WIDTH = DATA_WIDTH + 1;

  localparam logic [ADDR_WIDTH-1:0] BEAT_STEP = 4;

  localparam logic PAGE_CTRL = 1'b0;
  localparam logic PAGE_USER = 1'b1;

  localparam logic [REG_IDX_WIDTH-1:0] REG_INT_STATUS = 3'd0;
  localparam logic [REG_IDX_WIDTH-1:0] REG_INT_ENABLE = 3'd1;
  localparam logic [REG_IDX_WIDTH-1:0] REG_NUM_TILES = 3'd2;
  localparam logic [REG_IDX_WIDTH-1:0] REG_IND_COUNT = 3'd3;
  localparam logic [REG_IDX_WIDTH-1:0] REG_PORTAL_ID = 3'd4;
  localparam logic [REG_IDX_WIDTH-1:0] REG_NUM_PORTALS = 3'd5;

  localparam logic [DATA_WIDTH-1:0] NUM_TILES = 32'd1;
  localparam logic [DATA_WIDTH-1:0] PORTAL_ID = 32'd5;
  localparam logic [DATA_WIDTH-1:0] NUM_PORTALS = 32'd2;
  localparam logic [DATA_WIDTH-1:0] REG_DEFAULT = 32'h005A05A0;

  localparam logic [RESP_WIDTH-1:0] RESP_OKAY = 2'd0;

  // one beat address, seen as a control register or as a user channel word
  typedef union packed {
    struct packed {
      logic page;
      logic [CHAN_WIDTH-1:0] unused;
      logic [REG_IDX_WIDTH-1:0] regIdx;
      logic [1:0] byteSel;
    } ctrl;
    struct packed {
      logic page;
      logic [CHAN_WIDTH-1:0] channel;
      logic [OFFSET_WIDTH-1:0] offset;
      logic [1:0] byteSel;
    } user;
  } portalAddr_t;

endpackage
